// ==== src/fetch_align_pkg.sv ====
/*
  Shared types and constants of the fetch alignment buffer
  Instruction addresses are halfword aligned and bit 0 is ignored
  The outstanding limit is fixed by the request rule and is not tunable
*/
`default_nettype none

package fetch_align_pkg;

  // One fetch word or one instruction address
  typedef logic [31:0] word_t;

  // One instruction parcel
  typedef logic [15:0] half_t;

  // Default buffer depth in words
  // Depth 4 also works, depth below 2 does not
  localparam int unsigned ALBUF_DEPTH_DEFAULT = 3;

  // Fetch requests in flight at most
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Width of the outstanding and flush counters
  localparam int unsigned OUTSTND_W = 2;

  // Low two bits of a 32-bit parcel
  // Any other value marks a compressed instruction
  localparam logic [1:0] UNCOMPRESSED_OP = 2'b11;

endpackage

`default_nettype wire

// ==== src/fetch_req_ctrl.sv ====
/*
  Fetch request gating for the alignment buffer
  Counts outstanding requests and complete instructions held in the buffer
  A branch request must be accepted by the prefetcher in the branch cycle
  The instruction count lags one cycle behind the IF side on purpose
  Responses are expected only for accepted requests
*/
`default_nettype none

module fetch_req_ctrl import fetch_align_pkg::*; (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             instr_req_i,
  input  wire logic             branch_i,
  input  wire word_t            branch_addr_i,
  input  wire logic             fetch_ready_i,
  input  wire logic             resp_valid_i,
  input  wire word_t            resp_rdata_i,
  input  wire logic             resp_accept_i,
  input  wire logic             instr_taken_i,
  output logic                  fetch_valid_o,
  output logic                  fetch_branch_o,
  output word_t                 fetch_addr_o,
  output logic [OUTSTND_W-1:0]  outstnd_cnt_o,
  output logic                  prefetch_busy_o,
  output logic                  protocol_err_o
);

  // Instruction counter width, two per buffered word plus margin
  localparam int unsigned ICNT_W = 3;

  logic [ICNT_W-1:0]    instr_cnt_q;
  logic [ICNT_W-1:0]    instr_cnt_d;
  logic [ICNT_W-1:0]    instr_avail;
  logic [OUTSTND_W-1:0] outstnd_q;
  logic [OUTSTND_W-1:0] outstnd_d;
  logic                 pop_q;
  logic                 aligned_q;
  logic                 aligned_d;
  logic                 complete_q;
  logic                 complete_d;
  logic [1:0]           n_incoming;
  logic                 lo_uncomp;
  logic                 hi_uncomp;
  logic                 req_accept;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Instructions left after last cycle's pop
  assign instr_avail = instr_cnt_q - ICNT_W'(pop_q);

  // Fetch on a branch, or when the buffer runs dry
  assign fetch_valid_o = instr_req_i &&
                         (outstnd_q < OUTSTND_W'(MAX_OUTSTANDING)) &&
                         (branch_i ||
                          (instr_avail == '0) ||
                          ((instr_avail == ICNT_W'(1)) && (outstnd_q == '0)));

  assign fetch_branch_o = branch_i;
  assign fetch_addr_o   = {branch_addr_i[31:1], 1'b0};
  assign req_accept     = fetch_valid_o && fetch_ready_i;

  // Busy while a response is due or a request is raised
  assign prefetch_busy_o = (outstnd_q != '0) || fetch_valid_o;
  assign protocol_err_o  = resp_valid_i && (outstnd_q == '0);
  assign outstnd_cnt_o   = outstnd_q;

  always_comb begin
    outstnd_d = outstnd_q;
    if (req_accept && !resp_valid_i) begin
      outstnd_d = outstnd_q + 1'b1;
    end else if (!req_accept && resp_valid_i && (outstnd_q != '0)) begin
      outstnd_d = outstnd_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Complete instructions per accepted word
  //////////////////////////////////////////////////////////////////////

  assign lo_uncomp = (resp_rdata_i[1:0] == UNCOMPRESSED_OP);
  assign hi_uncomp = (resp_rdata_i[17:16] == UNCOMPRESSED_OP);

  // Unaligned and complete only right after an unaligned branch
  always_comb begin
    aligned_d  = aligned_q;
    complete_d = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      aligned_d  = !branch_addr_i[1];
      complete_d = branch_addr_i[1];
    end else if (resp_accept_i) begin
      if (aligned_q && lo_uncomp) begin
        // Whole word is one instruction
        n_incoming = 2'd1;
      end else begin
        // Lower half ends an instruction unless skipped after a branch
        n_incoming = {1'b0, aligned_q || !complete_q} + {1'b0, !hi_uncomp};
        // Uncompressed upper half straddles into the next word
        aligned_d  = !hi_uncomp;
        complete_d = !hi_uncomp;
      end
    end
  end

  // Buffer content is dropped on a branch
  assign instr_cnt_d = branch_i ? '0 :
                       instr_cnt_q + ICNT_W'(n_incoming) - ICNT_W'(pop_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_cnt_q <= '0;
      outstnd_q   <= '0;
      pop_q       <= 1'b0;
      aligned_q   <= 1'b1;
      complete_q  <= 1'b1;
    end else begin
      instr_cnt_q <= instr_cnt_d;
      outstnd_q   <= outstnd_d;
      pop_q       <= instr_taken_i;
      aligned_q   <= aligned_d;
      complete_q  <= complete_d;
    end
  end

  // Request rule and response ordering keep the count within the limit
  outstnd_limit_a : assert property (@(posedge clk) disable iff (!rst_n)
    outstnd_q <= OUTSTND_W'(MAX_OUTSTANDING))
    else $error("outstanding fetch count above limit");

endmodule

`default_nettype wire

// ==== src/resp_writer.sv ====
/*
  Response acceptance and buffer write pointer
  Responses still in flight at a branch are counted and dropped
  A response in the branch cycle itself is dropped as well
*/
`default_nettype none

module resp_writer import fetch_align_pkg::*; #(
  parameter int unsigned ALBUF_DEPTH = ALBUF_DEPTH_DEFAULT
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  branch_i,
  input  wire logic                  resp_valid_i,
  input  wire logic [OUTSTND_W-1:0]  outstnd_cnt_i,
  output logic                       resp_accept_o,
  output logic [ALBUF_DEPTH-1:0]     wr_en_o
);

  localparam int unsigned      PTR_W    = $clog2(ALBUF_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(ALBUF_DEPTH - 1);

  logic [OUTSTND_W-1:0] flush_q;
  logic [PTR_W-1:0]     wptr_q;

  // Keep only responses of the current stream
  assign resp_accept_o = resp_valid_i && (flush_q == '0) && !branch_i;

  // One-hot write strobe into the entry at the write pointer
  assign wr_en_o = resp_accept_o ? (ALBUF_DEPTH'(1) << wptr_q) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_q <= '0;
      wptr_q  <= '0;
    end else if (branch_i) begin
      wptr_q <= '0;
      // A response arriving now already counts as flushed
      if (resp_valid_i && (outstnd_cnt_i != '0)) begin
        flush_q <= outstnd_cnt_i - 1'b1;
      end else begin
        flush_q <= outstnd_cnt_i;
      end
    end else begin
      if (resp_valid_i && (flush_q != '0)) begin
        flush_q <= flush_q - 1'b1;
      end
      if (resp_accept_o) begin
        wptr_q <= (wptr_q == LAST_PTR) ? '0 : wptr_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/buffer_entry.sv ====
/*
  One word slot of the alignment buffer
  Compressed flags for both halves are taken at write time
  A write and a release together on an empty slot mean pass-through
*/
`default_nettype none

module buffer_entry import fetch_align_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   wr_en_i,
  input  wire logic   clr_i,
  input  wire logic   flush_i,
  input  wire word_t  wdata_i,
  input  wire logic   werr_i,
  output logic        valid_o,
  output word_t       data_o,
  output logic        err_o,
  output logic        lo_compressed_o,
  output logic        hi_compressed_o
);

  logic valid_q;

  // Payload
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      data_o          <= wdata_i;
      err_o           <= werr_i;
      lo_compressed_o <= (wdata_i[1:0] != UNCOMPRESSED_OP);
      hi_compressed_o <= (wdata_i[17:16] != UNCOMPRESSED_OP);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (wr_en_i) begin
      // Release of an empty slot consumes the incoming word
      valid_q <= valid_q || !clr_i;
    end else if (clr_i) begin
      valid_q <= 1'b0;
    end
  end

  assign valid_o = valid_q;

  // Writer and aligner pointers never overrun a held word
  no_overwrite_a : assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en_i && valid_q) |-> clr_i)
    else $error("buffer entry overwritten while valid");

endmodule

`default_nettype wire

// ==== src/instr_aligner.sv ====
/*
  Instruction aligner at the read side of the buffer
  Builds whole instructions from entries or from the response in flight
  Compressed instructions carry zeros in their upper 16 bits
  The entry at the read pointer is empty only when the buffer is empty
*/
`default_nettype none

module instr_aligner import fetch_align_pkg::*; #(
  parameter int unsigned ALBUF_DEPTH = ALBUF_DEPTH_DEFAULT
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      branch_i,
  input  wire word_t                     branch_addr_i,
  input  wire logic                      resp_accept_i,
  input  wire word_t                     resp_rdata_i,
  input  wire logic                      resp_err_i,
  input  wire logic                      instr_ready_i,
  input  wire logic [ALBUF_DEPTH-1:0]    ent_valid_i,
  input  wire word_t [ALBUF_DEPTH-1:0]   ent_data_i,
  input  wire logic [ALBUF_DEPTH-1:0]    ent_err_i,
  input  wire logic [ALBUF_DEPTH-1:0]    ent_lo_c_i,
  input  wire logic [ALBUF_DEPTH-1:0]    ent_hi_c_i,
  output logic                           instr_valid_o,
  output word_t                          instr_o,
  output word_t                          instr_addr_o,
  output logic                           instr_err_o,
  output logic                           instr_taken_o,
  output logic [ALBUF_DEPTH-1:0]         clr_o
);

  localparam int unsigned      PTR_W    = $clog2(ALBUF_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(ALBUF_DEPTH - 1);

  logic [PTR_W-1:0] rptr_q;
  logic [PTR_W-1:0] rptr2;
  word_t            addr_q;
  word_t            addr_d;
  word_t            addr_step;
  word_t            cur_word;
  logic             cur_err;
  half_t            nxt_half;
  logic             nxt_err;
  logic             lo_comp;
  logic             hi_comp;
  logic             avail_one;
  logic             avail_two;
  logic             instr_valid;
  logic             release_cur;

  //////////////////////////////////////////////////////////////////////
  // Source selection
  //////////////////////////////////////////////////////////////////////

  // Entry after the read pointer, wrapping
  assign rptr2 = (rptr_q == LAST_PTR) ? '0 : rptr_q + 1'b1;

  // Current entry, or the response passing straight through
  assign cur_word = ent_valid_i[rptr_q] ? ent_data_i[rptr_q] : resp_rdata_i;
  assign cur_err  = ent_valid_i[rptr_q] ? ent_err_i[rptr_q] : resp_err_i;
  assign lo_comp  = ent_valid_i[rptr_q] ? ent_lo_c_i[rptr_q] :
                    (resp_rdata_i[1:0] != UNCOMPRESSED_OP);
  assign hi_comp  = ent_valid_i[rptr_q] ? ent_hi_c_i[rptr_q] :
                    (resp_rdata_i[17:16] != UNCOMPRESSED_OP);

  // Lower half of the following word for straddling instructions
  assign nxt_half = ent_valid_i[rptr2] ? ent_data_i[rptr2][15:0] : resp_rdata_i[15:0];
  assign nxt_err  = ent_valid_i[rptr2] ? ent_err_i[rptr2] : resp_err_i;

  // One word or two consecutive words at hand
  assign avail_one = ent_valid_i[rptr_q] || resp_accept_i;
  assign avail_two = ent_valid_i[rptr2] || (ent_valid_i[rptr_q] && resp_accept_i);

  //////////////////////////////////////////////////////////////////////
  // Instruction output
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    instr_o     = cur_word;
    instr_err_o = cur_err;
    instr_valid = avail_one;
    if (addr_q[1]) begin
      if (hi_comp) begin
        instr_o = {16'h0000, cur_word[31:16]};
      end else begin
        // Straddler needs both words and both error bits
        instr_o     = {nxt_half, cur_word[31:16]};
        instr_err_o = cur_err || nxt_err;
        instr_valid = avail_two;
      end
    end else if (lo_comp) begin
      instr_o = {16'h0000, cur_word[15:0]};
    end
  end

  // Branch kills the instruction on offer
  assign instr_valid_o = instr_valid && !branch_i;
  assign instr_taken_o = instr_valid_o && instr_ready_i;
  assign instr_addr_o  = addr_q;

  //////////////////////////////////////////////////////////////////////
  // Address and read pointer
  //////////////////////////////////////////////////////////////////////

  assign addr_step = {addr_q[31:2] + 30'd1, 2'b00};

  // Entry is released once its upper half is used
  always_comb begin
    addr_d      = addr_step;
    release_cur = 1'b1;
    if (addr_q[1]) begin
      addr_d[1] = !hi_comp;
    end else if (lo_comp) begin
      addr_d      = {addr_q[31:2], 2'b10};
      release_cur = 1'b0;
    end
  end

  assign clr_o = (instr_taken_o && release_cur) ? (ALBUF_DEPTH'(1) << rptr_q) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      rptr_q <= '0;
    end else if (branch_i) begin
      addr_q <= {branch_addr_i[31:1], 1'b0};
      rptr_q <= '0;
    end else if (instr_taken_o) begin
      addr_q <= addr_d;
      if (release_cur) begin
        rptr_q <= rptr2;
      end
    end
  end

  // Stalled IF side sees the same instruction on the next cycle
  instr_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && !instr_ready_i) |=> ($stable(instr_o) && $stable(instr_addr_o)))
    else $error("instruction changed while stalled");

endmodule

`default_nettype wire

// ==== src/fetch_align_top.sv ====
/*
  Instruction alignment buffer between prefetcher and IF stage
  branch_i redirects fetch and discards all buffered words
  The first request after reset is expected to come with a branch
  Responses arrive in request order and are never refused
*/
`default_nettype none

module fetch_align_top import fetch_align_pkg::*; #(
  parameter int unsigned ALBUF_DEPTH = ALBUF_DEPTH_DEFAULT
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   instr_req_i,
  input  wire logic   branch_i,
  input  wire word_t  branch_addr_i,
  input  wire logic   fetch_ready_i,
  input  wire logic   resp_valid_i,
  input  wire word_t  resp_rdata_i,
  input  wire logic   resp_err_i,
  input  wire logic   instr_ready_i,
  output logic        fetch_valid_o,
  output logic        fetch_branch_o,
  output word_t       fetch_addr_o,
  output logic        instr_valid_o,
  output word_t       instr_o,
  output word_t       instr_addr_o,
  output logic        instr_err_o,
  output logic        prefetch_busy_o,
  output logic        protocol_err_o
);

  logic [OUTSTND_W-1:0]   outstnd_cnt;
  logic                   resp_accept;
  logic                   instr_taken;
  logic [ALBUF_DEPTH-1:0] wr_en;
  logic [ALBUF_DEPTH-1:0] clr;
  logic [ALBUF_DEPTH-1:0] ent_valid;
  word_t [ALBUF_DEPTH-1:0] ent_data;
  logic [ALBUF_DEPTH-1:0] ent_err;
  logic [ALBUF_DEPTH-1:0] ent_lo_c;
  logic [ALBUF_DEPTH-1:0] ent_hi_c;

  fetch_req_ctrl u_req_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .resp_rdata_i    (resp_rdata_i),
    .resp_accept_i   (resp_accept),
    .instr_taken_i   (instr_taken),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_branch_o  (fetch_branch_o),
    .fetch_addr_o    (fetch_addr_o),
    .outstnd_cnt_o   (outstnd_cnt),
    .prefetch_busy_o (prefetch_busy_o),
    .protocol_err_o  (protocol_err_o)
  );

  resp_writer #(
    .ALBUF_DEPTH (ALBUF_DEPTH)
  ) u_writer (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .resp_valid_i  (resp_valid_i),
    .outstnd_cnt_i (outstnd_cnt),
    .resp_accept_o (resp_accept),
    .wr_en_o       (wr_en)
  );

  // Word slots, flushed together on a branch
  for (genvar i = 0; i < ALBUF_DEPTH; i++) begin : g_entry
    buffer_entry u_entry (
      .clk             (clk),
      .rst_n           (rst_n),
      .wr_en_i         (wr_en[i]),
      .clr_i           (clr[i]),
      .flush_i         (branch_i),
      .wdata_i         (resp_rdata_i),
      .werr_i          (resp_err_i),
      .valid_o         (ent_valid[i]),
      .data_o          (ent_data[i]),
      .err_o           (ent_err[i]),
      .lo_compressed_o (ent_lo_c[i]),
      .hi_compressed_o (ent_hi_c[i])
    );
  end

  instr_aligner #(
    .ALBUF_DEPTH (ALBUF_DEPTH)
  ) u_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .instr_ready_i (instr_ready_i),
    .ent_valid_i   (ent_valid),
    .ent_data_i    (ent_data),
    .ent_err_i     (ent_err),
    .ent_lo_c_i    (ent_lo_c),
    .ent_hi_c_i    (ent_hi_c),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o),
    .instr_taken_o (instr_taken),
    .clr_o         (clr)
  );

endmodule

`default_nettype wire

// ==== verification/fetch_mem_model.sv ====
/*
  Prefetcher and word memory for the alignment buffer testbench
  Always ready, answers each accepted request one cycle later in order
  Memory image and fault bits are loaded by the testbench top
  Word index wraps at MEM_WORDS
*/
`default_nettype none

module fetch_mem_model import fetch_align_pkg::*; #(
  parameter int unsigned MEM_WORDS = 64
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   fetch_valid_i,
  input  wire logic   fetch_branch_i,
  input  wire word_t  fetch_addr_i,
  output logic        fetch_ready_o,
  output logic        resp_valid_o,
  output word_t       resp_rdata_o,
  output logic        resp_err_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // Word image and per-word fault marks
  word_t mem [MEM_WORDS];
  logic  bad [MEM_WORDS];

  word_t            next_addr_q;
  word_t            req_addr;
  logic [IDX_W-1:0] idx;

  assign fetch_ready_o = 1'b1;

  // Branch requests restart at the target word, others run sequentially
  assign req_addr = fetch_branch_i ? {fetch_addr_i[31:2], 2'b00} : next_addr_q;
  assign idx      = req_addr[IDX_W+1:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr_q  <= '0;
      resp_valid_o <= 1'b0;
      resp_rdata_o <= '0;
      resp_err_o   <= 1'b0;
    end else begin
      resp_valid_o <= fetch_valid_i && fetch_ready_o;
      if (fetch_valid_i && fetch_ready_o) begin
        resp_rdata_o <= mem[idx];
        resp_err_o   <= bad[idx];
        next_addr_q  <= req_addr + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/fetch_align_tb.sv ====
/*
  Testbench for the instruction alignment buffer
  Each table row loads a memory image, branches to a target and checks
  a number of delivered instructions against a stream built from the image
  Outputs are sampled at the falling edge and inputs driven 2 ns after the rising edge
  The memory index wraps at 256 bytes and all targets stay well inside
*/
`default_nettype none

module fetch_align_tb import fetch_align_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_TESTS    = 7;
  localparam int unsigned MAX_CHECK    = 64;
  localparam int unsigned MEM_WORDS    = 64;
  localparam int unsigned RESET_CYCLES = 4;

  // One row of the test table
  typedef struct packed {
    logic [1:0] sel;
    word_t      target;
    word_t      pre_addr;
    logic [3:0] pre_cyc;
    logic       rnd_ready;
    logic [7:0] n_instr;
  } test_t;

  logic  clk;
  logic  rst_n;
  logic  instr_req_i;
  logic  branch_i;
  word_t branch_addr_i;
  logic  instr_ready_i;
  logic  fetch_ready;
  logic  resp_valid;
  word_t resp_rdata;
  logic  resp_err;
  logic  fetch_valid_o;
  logic  fetch_branch_o;
  word_t fetch_addr_o;
  logic  instr_valid_o;
  word_t instr_o;
  word_t instr_addr_o;
  logic  instr_err_o;
  logic  prefetch_busy_o;
  logic  protocol_err_o;

  test_t  tests [NUM_TESTS];
  word_t  exp_instr [MAX_CHECK];
  word_t  exp_addr [MAX_CHECK];
  logic   exp_err [MAX_CHECK];
  logic   exp_comp [MAX_CHECK];
  integer seed;
  int     err_count = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;

  fetch_align_top #(
    .ALBUF_DEPTH (ALBUF_DEPTH_DEFAULT)
  ) UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .fetch_ready_i   (fetch_ready),
    .resp_valid_i    (resp_valid),
    .resp_rdata_i    (resp_rdata),
    .resp_err_i      (resp_err),
    .instr_ready_i   (instr_ready_i),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_branch_o  (fetch_branch_o),
    .fetch_addr_o    (fetch_addr_o),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .instr_addr_o    (instr_addr_o),
    .instr_err_o     (instr_err_o),
    .prefetch_busy_o (prefetch_busy_o),
    .protocol_err_o  (protocol_err_o)
  );

  fetch_mem_model #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid_i  (fetch_valid_o),
    .fetch_branch_i (fetch_branch_o),
    .fetch_addr_i   (fetch_addr_o),
    .fetch_ready_o  (fetch_ready),
    .resp_valid_o   (resp_valid),
    .resp_rdata_o   (resp_rdata),
    .resp_err_o     (resp_err)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Memory images
  //////////////////////////////////////////////////////////////////////

  // Parcel at halfword index k
  // Image 0 holds uncompressed words only and images 1 and 2 mix pairs and straddlers
  function automatic half_t image_parcel(input logic [1:0] sel, input logic [6:0] k);
    logic [1:0] low;
    logic [2:0] pos;
    pos = k[2:0];
    if (sel == 2'd0) begin
      low = k[0] ? k[2:1] : UNCOMPRESSED_OP;
    end else if ((pos == 3'd2) || (pos == 3'd5)) begin
      low = UNCOMPRESSED_OP;
    end else begin
      low = 2'(k % 7'd3);
    end
    return {k, (k * 7'd3) ^ 7'h55, low};
  endfunction

  // Image 2 marks words 3 and 6 as faulty
  function automatic logic image_faulty(input logic [1:0] sel, input logic [5:0] w);
    return (sel == 2'd2) && ((w == 6'd3) || (w == 6'd6));
  endfunction

  task automatic load_image(input logic [1:0] sel);
    for (int w = 0; w < MEM_WORDS; w++) begin
      u_mem.mem[w] = {image_parcel(sel, 7'(2 * w + 1)), image_parcel(sel, 7'(2 * w))};
      u_mem.bad[w] = image_faulty(sel, 6'(w));
    end
  endtask

  // Walk the image from the target and record the instruction stream
  task automatic build_expected(input test_t r);
    word_t      addr;
    logic [6:0] k;
    logic [6:0] k_next;
    half_t      p;
    addr = {r.target[31:1], 1'b0};
    for (int i = 0; i < r.n_instr; i++) begin
      k           = addr[7:1];
      k_next      = k + 7'd1;
      p           = image_parcel(r.sel, k);
      exp_addr[i] = addr;
      if (p[1:0] == UNCOMPRESSED_OP) begin
        exp_instr[i] = {image_parcel(r.sel, k_next), p};
        exp_err[i]   = image_faulty(r.sel, k[6:1]) || image_faulty(r.sel, k_next[6:1]);
        exp_comp[i]  = 1'b0;
        addr         = addr + 32'd4;
      end else begin
        exp_instr[i] = {16'h0000, p};
        exp_err[i]   = image_faulty(r.sel, k[6:1]);
        exp_comp[i]  = 1'b1;
        addr         = addr + 32'd2;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  function automatic test_t make_test(input logic [1:0] sel, input word_t target,
                                      input word_t pre_addr, input logic [3:0] pre_cyc,
                                      input logic rnd_ready, input logic [7:0] n_instr);
    test_t r;
    r.sel       = sel;
    r.target    = target;
    r.pre_addr  = pre_addr;
    r.pre_cyc   = pre_cyc;
    r.rnd_ready = rnd_ready;
    r.n_instr   = n_instr;
    return r;
  endfunction

  // One-cycle branch strobe with fetching enabled
  task automatic take_branch(input word_t addr);
    @(posedge clk);
    #2;
    branch_i      = 1'b1;
    branch_addr_i = addr;
    instr_req_i   = 1'b1;
    instr_ready_i = 1'b1;
    // Branch request leaves in the same cycle at the target with bit 0 cleared
    @(negedge clk);
    compare("fetch_valid_o", fetch_valid_o, 1'b1);
    compare("fetch_branch_o", fetch_branch_o, 1'b1);
    compare("fetch_addr_o", fetch_addr_o, addr & 32'hffff_fffe);
  endtask

  task automatic run_test(input int t);
    test_t       r;
    int          got;
    int          start_err;
    int          wait_cyc;
    logic [31:0] rv;
    r         = tests[t];
    start_err = err_count;
    load_image(r.sel);
    build_expected(r);
    // Optional first stream that the target branch kills with requests in flight
    if (r.pre_cyc != 0) begin
      take_branch(r.pre_addr);
      repeat (r.pre_cyc) begin
        @(posedge clk);
        #2;
        branch_i      = 1'b0;
        instr_ready_i = 1'b1;
      end
    end
    take_branch(r.target);
    got = 0;
    while (got < r.n_instr) begin
      @(posedge clk);
      #2;
      branch_i      = 1'b0;
      rv            = $random(seed);
      instr_ready_i = r.rnd_ready ? (rv[1:0] != 2'b00) : 1'b1;
      @(negedge clk);
      if (instr_valid_o && instr_ready_i) begin
        compare("instr_addr_o", instr_addr_o, exp_addr[got]);
        if (exp_comp[got]) begin
          compare("instr_o[15:0]", {16'h0000, instr_o[15:0]}, exp_instr[got]);
        end else begin
          compare("instr_o", instr_o, exp_instr[got]);
        end
        compare("instr_err_o", instr_err_o, exp_err[got]);
        got++;
      end
    end
    // Stop fetching and let the last responses return
    @(posedge clk);
    #2;
    instr_req_i   = 1'b0;
    instr_ready_i = 1'b0;
    @(negedge clk);
    wait_cyc = 0;
    while (prefetch_busy_o && (wait_cyc < 4)) begin
      @(negedge clk);
      wait_cyc++;
    end
    compare("prefetch_busy_o", prefetch_busy_o, 1'b0);
    if (err_count == start_err) begin
      pass_cnt++;
      $display("Test %0d ok: %0d instructions from %h", t, r.n_instr, r.target);
    end else begin
      fail_cnt++;
      $display("Test %0d FAILED: %0d errors", t, err_count - start_err);
    end
  endtask

  // No response may arrive without a request in flight
  always @(negedge clk) begin
    if (rst_n) begin
      compare("protocol_err_o", protocol_err_o, 1'b0);
    end
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int total;
    int start_err;
    seed          = 32'ha88;
    rst_n         = 1'b0;
    instr_req_i   = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;

    //           image target        pre addr      pre  rnd  count
    tests[0] = make_test(2'd0, 32'h0000_0020, 32'h0, 4'd0, 1'b0, 8'd12);
    tests[1] = make_test(2'd1, 32'h0000_0040, 32'h0, 4'd0, 1'b0, 8'd24);
    tests[2] = make_test(2'd1, 32'h0000_002a, 32'h0, 4'd0, 1'b0, 8'd16);
    tests[3] = make_test(2'd1, 32'h0000_0060, 32'h0000_00c0, 4'd1, 1'b0, 8'd16);
    tests[4] = make_test(2'd2, 32'h0000_0008, 32'h0, 4'd0, 1'b0, 8'd20);
    tests[5] = make_test(2'd1, 32'h0000_0002, 32'h0, 4'd0, 1'b1, 8'd40);
    tests[6] = make_test(2'd2, 32'h0000_0012, 32'h0000_0080, 4'd1, 1'b1, 8'd20);

    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += tests[t].n_instr;
    end
    cycle_limit = 40 * total + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle state right after reset
    start_err = err_count;
    @(negedge clk);
    compare("fetch_valid_o", fetch_valid_o, 1'b0);
    compare("instr_valid_o", instr_valid_o, 1'b0);
    compare("prefetch_busy_o", prefetch_busy_o, 1'b0);
    compare("instr_addr_o", instr_addr_o, 32'h0);
    if (err_count == start_err) begin
      pass_cnt++;
      $display("Reset check ok");
    end else begin
      fail_cnt++;
      $display("Reset check FAILED");
    end

    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end

    $display("Summary: %0d passed, %0d failed, %0d mismatches", pass_cnt, fail_cnt, err_count);
    if ((fail_cnt == 0) && (err_count == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/fetch_align_pkg.sv
src/fetch_req_ctrl.sv
src/resp_writer.sv
src/buffer_entry.sv
src/instr_aligner.sv
src/fetch_align_top.sv
verification/fetch_mem_model.sv
verification/fetch_align_tb.sv
